//--- tb.f
design/fb_pkg.sv
design/pattern_renderer.sv
design/raster_scanout.sv
design/dbuf_bank_switch.sv
design/gfx_demo_dbuf.sv
bench/gfx_demo_assert.sv
bench/tb_gfx_demo_dbuf.sv

//--- Makefile
# Verilator build and run for the double-buffered frame buffer demo

VERILATOR ?= verilator
TOP       ?= tb_gfx_demo_dbuf
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --assert --timing

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_gfx_demo_dbuf.sv
`timescale 1ns/1ns

module tb_gfx_demo_dbuf;
  import fb_pkg::*;

  // default geometry of the DUT
  localparam int H_TOTAL      = 16 + 2 + 3 + 3;
  localparam int V_TOTAL      = 8 + 1 + 2 + 1;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

  localparam int RESET_CYCLES   = 8;
  localparam int FIRST_FRAMES   = 12;
  localparam int SECOND_FRAMES  = 6;
  localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 600;
  localparam logic [31:0] SEED  = 32'd83805;

  logic   clk;
  logic   reset;
  video_t video;

  logic [31:0] rand_state;
  logic        passed        = 1'b0;
  logic        fail_reported = 1'b0;
  int          cycle_cnt     = 0;

  gfx_demo_dbuf i_dut (
    .clk  (clk),
    .reset(reset),
    .video(video)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // numerical recipes constants
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one displayed frame ends at each falling edge of vsync
  task automatic wait_frames(input int n);
    int   seen;
    logic prev;
    seen = 0;
    prev = video.vsync;
    while (seen < n) begin
      @(negedge clk);
      if (prev && !video.vsync) begin
        seen++;
      end
      prev = video.vsync;
    end
  endtask

  initial begin
    int delay;
    reset      = 1'b1;
    rand_state = SEED;

    // first reset is already high from time zero
    wait_cycles(RESET_CYCLES);
    reset <= 1'b0;
    wait_frames(FIRST_FRAMES);

    // second reset lands at an arbitrary point of the raster
    rand_state = next_random(rand_state);
    delay      = int'(rand_state[15:8]);
    wait_cycles(delay);
    apply_reset();
    wait_frames(SECOND_FRAMES);

    passed = 1'b1;
    $display("*** PASSED ***");
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_reported = 1'b1;
      $display("timeout after %0d cycles, expected frames were not displayed", cycle_cnt);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // run stopped early by an assertion
  final begin
    if (!passed && !fail_reported) begin
      $display("*** FAILED ***");
    end
  end

endmodule

//--- bench/gfx_demo_assert.sv
`timescale 1ns/1ns

module gfx_demo_assert #(
  parameter int H_VISIBLE = 16,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 3,
  parameter int H_BACK    = 3,
  parameter int V_VISIBLE = 8,
  parameter int V_SYNC    = 2
) (
  input logic           clk,
  input logic           reset,
  input fb_pkg::video_t video
);
  import fb_pkg::*;

  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // previous cycle of the video output for edge detection
  logic hs_q;
  logic vs_q;
  logic de_q;
  logic hs_rise;
  logic hs_fall;
  logic vs_rise;
  logic vs_fall;
  logic de_fall;
  logic hs_seen;
  logic de_seen;

  int hs_len;
  int hs_since;
  int vs_len;
  int col;
  int row;
  int frame_cnt;

  assign hs_rise = video.hsync && !hs_q;
  assign hs_fall = !video.hsync && hs_q;
  assign vs_rise = video.vsync && !vs_q;
  assign vs_fall = !video.vsync && vs_q;
  assign de_fall = !video.de && de_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      hs_q      <= 1'b0;
      vs_q      <= 1'b0;
      de_q      <= 1'b0;
      hs_seen   <= 1'b0;
      de_seen   <= 1'b0;
      hs_len    <= 0;
      hs_since  <= 0;
      vs_len    <= 0;
      col       <= 0;
      row       <= 0;
      frame_cnt <= 0;
    end else begin
      hs_q     <= video.hsync;
      vs_q     <= video.vsync;
      de_q     <= video.de;
      hs_seen  <= hs_seen || hs_rise;
      de_seen  <= de_seen || video.de;
      hs_len   <= video.hsync ? hs_len + 1 : 0;
      vs_len   <= video.vsync ? vs_len + 1 : 0;
      hs_since <= hs_rise ? 1 : hs_since + 1;
      // column within the current de run
      col      <= video.de ? col + 1 : 0;
      if (video.vsync) begin
        row <= 0;
      end else if (de_fall) begin
        row <= row + 1;
      end
      // a displayed frame ends with its vsync pulse
      if (vs_fall) begin
        frame_cnt <= frame_cnt + 1;
      end
    end
  end

  a_idle_zero: assert property (@(posedge clk) disable iff (reset)
    !de_seen && !video.de |-> video == '0)
    else $error("** Error %0t: video not idle before the first frame", $time);

  a_hs_len: assert property (@(posedge clk) disable iff (reset)
    hs_fall |-> hs_len == H_SYNC)
    else $error("** Error %0t: hsync pulse lasted %0d cycles", $time, hs_len);

  a_hs_period: assert property (@(posedge clk) disable iff (reset)
    hs_rise && hs_seen |-> hs_since == H_TOTAL)
    else $error("** Error %0t: hsync rises %0d cycles apart", $time, hs_since);

  a_vs_len: assert property (@(posedge clk) disable iff (reset)
    vs_fall |-> vs_len == V_SYNC * H_TOTAL)
    else $error("** Error %0t: vsync pulse lasted %0d cycles", $time, vs_len);

  a_de_blank: assert property (@(posedge clk) disable iff (reset)
    !(video.de && (video.hsync || video.vsync)))
    else $error("** Error %0t: de high during a sync pulse", $time);

  a_de_run: assert property (@(posedge clk) disable iff (reset)
    de_fall |-> col == H_VISIBLE)
    else $error("** Error %0t: de run of %0d cycles", $time, col);

  a_row_count: assert property (@(posedge clk) disable iff (reset)
    vs_rise |-> row == V_VISIBLE)
    else $error("** Error %0t: %0d de runs before vsync", $time, row);

  a_pixel_pos: assert property (@(posedge clk) disable iff (reset)
    video.de |-> video.px.red == COLOR_BITS'(col) && video.px.grn == COLOR_BITS'(row))
    else $error("** Error %0t: pixel colour does not match column %0d row %0d",
                $time, col, row);

  a_frame_id: assert property (@(posedge clk) disable iff (reset)
    video.de |-> video.px.blu == COLOR_BITS'(frame_cnt))
    else $error("** Error %0t: blue %0d in displayed frame %0d", $time,
                video.px.blu, frame_cnt);

endmodule

bind gfx_demo_dbuf gfx_demo_assert #(
  .H_VISIBLE(H_VISIBLE),
  .H_FRONT  (H_FRONT),
  .H_SYNC   (H_SYNC),
  .H_BACK   (H_BACK),
  .V_VISIBLE(V_VISIBLE),
  .V_SYNC   (V_SYNC)
) i_assert (
  .clk  (clk),
  .reset(reset),
  .video(video)
);

//--- design/gfx_demo_dbuf.sv
`timescale 1ns/1ns

module gfx_demo_dbuf #(
  parameter int H_VISIBLE = 16,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 3,
  parameter int H_BACK    = 3,
  parameter int V_VISIBLE = 8,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 1
) (
  input  logic           clk,
  input  logic           reset,
  output fb_pkg::video_t video
);
  import fb_pkg::*;

  // renderer to switcher
  fb_write_t wr;
  logic      wr_valid;
  logic      wr_ready;
  logic      frame_done;
  logic      restart;

  // scanout to switcher
  logic [FB_ADDR_BITS-1:0] rd_addr;
  logic                    rd_en;
  pixel_t                  rd_pixel;
  logic                    vsync_end;
  logic                    scan_enable;

  pattern_renderer #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
  ) i_renderer (
    .clk       (clk),
    .reset     (reset),
    .restart   (restart),
    .wr        (wr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .frame_done(frame_done)
  );

  raster_scanout #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) i_scanout (
    .clk      (clk),
    .reset    (reset),
    .enable   (scan_enable),
    .rd_addr  (rd_addr),
    .rd_en    (rd_en),
    .rd_pixel (rd_pixel),
    .vsync_end(vsync_end),
    .video    (video)
  );

  dbuf_bank_switch #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
  ) i_switch (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .wr_valid   (wr_valid),
    .wr_ready   (wr_ready),
    .frame_done (frame_done),
    .restart    (restart),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .rd_pixel   (rd_pixel),
    .vsync_end  (vsync_end),
    .scan_enable(scan_enable)
  );

endmodule

//--- design/dbuf_bank_switch.sv
`timescale 1ns/1ns

module dbuf_bank_switch #(
  parameter int H_VISIBLE = 16,
  parameter int V_VISIBLE = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  fb_pkg::fb_write_t               wr,
  input  logic                            wr_valid,
  output logic                            wr_ready,
  input  logic                            frame_done,
  output logic                            restart,
  input  logic [fb_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  logic                            rd_en,
  output fb_pkg::pixel_t                  rd_pixel,
  input  logic                            vsync_end,
  output logic                            scan_enable
);
  import fb_pkg::*;

  localparam int DEPTH      = H_VISIBLE * V_VISIBLE;
  localparam int DEPTH_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic {
    WAIT_FIRST,
    RUNNING
  } swap_state_t;

  swap_state_t state;

  // high for exactly one cycle, the cycle in which the banks trade places
  logic swap_q;

  // index of the bank being scanned out, the other one is written
  logic front_sel;
  logic back_sel;
  logic wr_fire;

  // bank that served the read in flight
  logic rd_sel_q;

  logic [DEPTH_BITS-1:0] wr_index;
  logic [DEPTH_BITS-1:0] rd_index;

  assign back_sel = ~front_sel;
  assign wr_ready = ~swap_q;
  assign restart  = swap_q;
  assign wr_fire  = wr_valid && wr_ready;
  assign wr_index = wr.addr[DEPTH_BITS-1:0];
  assign rd_index = rd_addr[DEPTH_BITS-1:0];

  assign scan_enable = (state == RUNNING);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= WAIT_FIRST;
      swap_q    <= 1'b0;
      front_sel <= 1'b1;
    end else begin
      case (state)
        WAIT_FIRST: begin
          // first frame complete, show it as soon as the banks swap
          swap_q <= frame_done;
          if (swap_q) begin
            state <= RUNNING;
          end
        end
        RUNNING: begin
          swap_q <= vsync_end;
        end
        default: begin
          state <= WAIT_FIRST;
        end
      endcase

      if (swap_q) begin
        front_sel <= ~front_sel;
      end
    end
  end

  // two identical banks, one written and one read at any time
  for (genvar b = 0; b < 2; b++) begin : g_bank
    pixel_t mem [DEPTH];
    pixel_t rd_q;

    always_ff @(posedge clk) begin
      if (wr_fire && (back_sel == 1'(b))) begin
        mem[wr_index] <= wr.px;
      end
      if (rd_en && (front_sel == 1'(b))) begin
        rd_q <= mem[rd_index];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_sel_q <= front_sel;
    end
  end

  // one cycle read latency through the selected bank register
  assign rd_pixel = rd_sel_q ? g_bank[1].rd_q : g_bank[0].rd_q;

endmodule

//--- design/raster_scanout.sv
`timescale 1ns/1ns

module raster_scanout #(
  parameter int H_VISIBLE = 16,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 3,
  parameter int H_BACK    = 3,
  parameter int V_VISIBLE = 8,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 1
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            enable,
  output logic [fb_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output logic                            rd_en,
  input  fb_pkg::pixel_t                  rd_pixel,
  output logic                            vsync_end,
  output fb_pkg::video_t                  video
);
  import fb_pkg::*;

  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_BITS  = $clog2(H_TOTAL);
  localparam int V_BITS  = $clog2(V_TOTAL);

  // column and line boundaries at counter width
  localparam logic [H_BITS-1:0] H_VIS_END    = H_BITS'(H_VISIBLE);
  localparam logic [H_BITS-1:0] H_SYNC_START = H_BITS'(H_VISIBLE + H_FRONT);
  localparam logic [H_BITS-1:0] H_SYNC_END   = H_BITS'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam logic [H_BITS-1:0] H_LAST       = H_BITS'(H_TOTAL - 1);
  localparam logic [V_BITS-1:0] V_VIS_END    = V_BITS'(V_VISIBLE);
  localparam logic [V_BITS-1:0] V_SYNC_START = V_BITS'(V_VISIBLE + V_FRONT);
  localparam logic [V_BITS-1:0] V_SYNC_END   = V_BITS'(V_VISIBLE + V_FRONT + V_SYNC);
  localparam logic [V_BITS-1:0] V_SYNC_LAST  = V_BITS'(V_VISIBLE + V_FRONT + V_SYNC - 1);
  localparam logic [V_BITS-1:0] V_LAST       = V_BITS'(V_TOTAL - 1);

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;

  // stage 0, decoded straight from the counters
  logic de0;
  logic hs0;
  logic vs0;

  // stage 1, aligned with the memory read data
  logic de1;
  logic hs1;
  logic vs1;

  // held at the top left corner until the first frame is ready
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      if (v_cnt == V_LAST) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + V_BITS'(1);
      end
    end else begin
      h_cnt <= h_cnt + H_BITS'(1);
    end
  end

  assign de0 = enable && (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);
  assign hs0 = enable && (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
  assign vs0 = enable && (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

  // front bank fetch for the visible area only
  assign rd_en   = de0;
  assign rd_addr = FB_ADDR_BITS'(v_cnt) * FB_ADDR_BITS'(H_VISIBLE) + FB_ADDR_BITS'(h_cnt);

  // last cycle of the vsync pulse, the switcher swaps on the next one
  assign vsync_end = enable && (v_cnt == V_SYNC_LAST) && (h_cnt == H_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      de1 <= 1'b0;
      hs1 <= 1'b0;
      vs1 <= 1'b0;
    end else begin
      de1 <= de0;
      hs1 <= hs0;
      vs1 <= vs0;
    end
  end

  // output register, colour blanked outside the visible area
  always_ff @(posedge clk) begin
    if (reset) begin
      video <= '0;
    end else begin
      video.hsync <= hs1;
      video.vsync <= vs1;
      video.de    <= de1;
      video.px    <= de1 ? rd_pixel : '0;
    end
  end

endmodule

//--- design/pattern_renderer.sv
`timescale 1ns/1ns

module pattern_renderer #(
  parameter int H_VISIBLE = 16,
  parameter int V_VISIBLE = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              restart,
  output fb_pkg::fb_write_t wr,
  output logic              wr_valid,
  input  logic              wr_ready,
  output logic              frame_done
);
  import fb_pkg::*;

  localparam int X_BITS = (H_VISIBLE > 1) ? $clog2(H_VISIBLE) : 1;
  localparam int Y_BITS = (V_VISIBLE > 1) ? $clog2(V_VISIBLE) : 1;
  localparam logic [X_BITS-1:0] X_LAST = X_BITS'(H_VISIBLE - 1);
  localparam logic [Y_BITS-1:0] Y_LAST = Y_BITS'(V_VISIBLE - 1);

  typedef enum logic {
    RENDERING,
    FINISHED
  } render_state_t;

  render_state_t     state;
  logic [X_BITS-1:0] x;
  logic [Y_BITS-1:0] y;
  logic [7:0]        frame_num;
  logic              accept;
  logic              last_pixel;

  assign wr_valid   = (state == RENDERING);
  assign accept     = wr_valid && wr_ready;
  assign last_pixel = (x == X_LAST) && (y == Y_LAST);

  // pulses together with the acceptance of the final pixel
  assign frame_done = accept && last_pixel;

  // write payload follows the counters, so it holds until accepted
  always_comb begin
    wr.addr   = FB_ADDR_BITS'(y) * FB_ADDR_BITS'(H_VISIBLE) + FB_ADDR_BITS'(x);
    wr.px.red = COLOR_BITS'(x);
    wr.px.grn = COLOR_BITS'(y);
    wr.px.blu = frame_num[COLOR_BITS-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= RENDERING;
      x         <= '0;
      y         <= '0;
      frame_num <= '0;
    end else if (restart) begin
      // new back bank, start over with the next frame number
      state     <= RENDERING;
      x         <= '0;
      y         <= '0;
      frame_num <= frame_num + 8'd1;
    end else if (accept) begin
      if (x == X_LAST) begin
        x <= '0;
        if (last_pixel) begin
          y     <= '0;
          state <= FINISHED;
        end else begin
          y <= y + Y_BITS'(1);
        end
      end else begin
        x <= x + X_BITS'(1);
      end
    end
  end

endmodule

//--- design/fb_pkg.sv
package fb_pkg;

  // frame buffer address width, 1024 pixels per bank at most
  localparam int FB_ADDR_BITS = 10;

  // bits per colour channel
  localparam int COLOR_BITS = 4;

  // 12-bit rgb pixel as stored in the frame buffer
  typedef struct packed {
    logic [COLOR_BITS-1:0] red;
    logic [COLOR_BITS-1:0] grn;
    logic [COLOR_BITS-1:0] blu;
  } pixel_t;

  // one renderer write into the back bank
  typedef struct packed {
    logic [FB_ADDR_BITS-1:0] addr;
    pixel_t                  px;
  } fb_write_t;

  // registered video output of the scanout
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    logic   de;
    pixel_t px;
  } video_t;

endpackage
